// ==== analog_input_top.f ====
verilog/analog_pkg.sv
verilog/mouse_packet_decoder.sv
verilog/mouse_axis_accum.sv
verilog/joystick_port_mapper.sv
verilog/analog_input_top.sv
bench/tb_analog_input.sv

// ==== bench/tb_analog_input.sv ====
/*
  directed testbench for the analog joystick front end
  clock, reset, lfsr, reference model, check task, test tasks, timeout
*/

`timescale 1ns/1ps

module tb_analog_input;

	localparam int LIMIT        = 10;
	// drive edge plus three edges of latency
	localparam int STEP_CYCLES  = 4;
	localparam int RESET_CYCLES = 3;
	localparam int TEST_STEPS   = 84;
	localparam int MAX_CYCLES   = 2 * (RESET_CYCLES + TEST_STEPS * STEP_CYCLES);

	logic clk_sys = 1'b0;
	logic reset;
	analog_pkg::mouse_pkt_t mouse_pkt;
	logic mouse_disable, port_swap, joy2_fire;
	logic [15:0] joy1;
	analog_pkg::joy_axis_t joy1_x, joy1_y, joy2_x, joy2_y;
	analog_pkg::port_axis_t port1_x, port1_y, port2_x, port2_y;
	logic port1_fire_n, port2_fire_n;

	// reference model state
	int   model_x, model_y;
	logic model_mouse, model_fire, stb;
	logic [31:0] lfsr_state = 32'h4b46c45c;
	int   cycle_count = 0;

	analog_input_top #(.delta_limit(LIMIT)) u_dut (
		.clk_sys(clk_sys), .reset(reset), .mouse_pkt(mouse_pkt),
		.mouse_disable(mouse_disable), .port_swap(port_swap), .joy1(joy1),
		.joy1_x(joy1_x), .joy1_y(joy1_y), .joy2_fire(joy2_fire),
		.joy2_x(joy2_x), .joy2_y(joy2_y), .port1_x(port1_x), .port1_y(port1_y),
		.port2_x(port2_x), .port2_y(port2_y),
		.port1_fire_n(port1_fire_n), .port2_fire_n(port2_fire_n)
	);

	always #20 clk_sys = ~clk_sys;

	// ==============================
	// timeout
	// ==============================
	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: run went past %0d clock cycles", MAX_CYCLES);
			$display("RESULT: FAIL");
			$fatal(1, "simulation timeout");
		end
	end

	// fibonacci lfsr with taps 32 22 2 1 stepped once per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	// halve the 9-bit movement and clamp it
	function automatic int half_clamp(input logic sign, input logic [7:0] mv);
		int m;
		m = sign ? int'(mv) - 256 : int'(mv);
		m = m >>> 1;
		if (m > LIMIT) return LIMIT;
		if (m < -LIMIT) return -LIMIT;
		return m;
	endfunction

	function automatic int saturate(input int v);
		return (v > 127) ? 127 : ((v < -128) ? -128 : v);
	endfunction

	// inverted offset binary is 127 - s with the top nibble repeated
	function automatic logic [11:0] port_val(input int s);
		int c;
		c = 127 - s;
		return {c[7:0], c[7:4]};
	endfunction

	task automatic compare(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
		if (act_v !== exp_v) begin
			$display("** Error: %s expected %h, got %h", name, exp_v, act_v);
			$display("RESULT: FAIL");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	// wait out the latency and check all ports mid-cycle
	task automatic settle_and_check();
		logic [11:0] ax, ay, bx, by;
		logic af;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		ax = model_mouse ? port_val(model_x) : port_val($signed(joy1_x));
		ay = model_mouse ? port_val(model_y) : port_val($signed(joy1_y));
		af = model_mouse ? model_fire : joy1[4];
		bx = port_val($signed(joy2_x));
		by = port_val($signed(joy2_y));
		compare("port1_x", port_swap ? bx : ax, port1_x);
		compare("port1_y", port_swap ? by : ay, port1_y);
		compare("port2_x", port_swap ? ax : bx, port2_x);
		compare("port2_y", port_swap ? ay : by, port2_y);
		compare("port1_fire_n", !(port_swap ? joy2_fire : af), port1_fire_n);
		compare("port2_fire_n", !(port_swap ? af : joy2_fire), port2_fire_n);
	endtask

	task automatic clear_model();
		model_x = 0;
		model_y = 0;
		model_mouse = 1'b0;
		model_fire = 1'b0;
	endtask

	task automatic set_joysticks(input logic [15:0] j1, input logic [7:0] j1x,
	                             input logic [7:0] j1y, input logic j2f,
	                             input logic [7:0] j2x, input logic [7:0] j2y);
		@(posedge clk_sys);
		joy1 <= j1;
		joy1_x <= j1x;
		joy1_y <= j1y;
		joy2_fire <= j2f;
		joy2_x <= j2x;
		joy2_y <= j2y;
		if (j1 != 0 || mouse_disable)
			clear_model();
		settle_and_check();
	endtask

	// new packet by toggling the strobe
	task automatic send_packet(input logic [1:0] btn, input logic xs, input logic [7:0] xm,
	                           input logic ys, input logic [7:0] ym);
		analog_pkg::mouse_pkt_t p;
		@(posedge clk_sys);
		stb = ~stb;
		p = '0;
		p[24] = stb;
		p[1:0] = btn;
		p[4] = xs;
		p[5] = ys;
		p[15:8] = xm;
		p[23:16] = ym;
		mouse_pkt <= p;
		// ignored while a clear condition holds
		if (joy1 == 0 && !mouse_disable) begin
			model_x = saturate(model_x + half_clamp(xs, xm));
			model_y = saturate(model_y - half_clamp(ys, ym));
			model_mouse = 1'b1;
			model_fire = |btn;
		end
		settle_and_check();
	endtask

	task automatic set_disable(input logic d);
		@(posedge clk_sys);
		mouse_disable <= d;
		if (d)
			clear_model();
		settle_and_check();
	endtask

	task automatic set_swap(input logic s);
		@(posedge clk_sys);
		port_swap <= s;
		settle_and_check();
	endtask

	// ==============================
	// tests
	// ==============================
	task automatic test_reset_state();
		reset <= 1'b0;
		settle_and_check();
		compare("port1_x", 12'h7F7, port1_x);
		compare("port2_y", 12'h7F7, port2_y);
		compare("port1_fire_n", 1, port1_fire_n);
		compare("port2_fire_n", 1, port2_fire_n);
	endtask

	task automatic test_joystick_passthrough();
		for (int i = 0; i < 20; i++)
			set_joysticks(take_bits(16), take_bits(8), take_bits(8),
			              take_bits(1), take_bits(8), take_bits(8));
	endtask

	task automatic test_mouse_emulation();
		set_joysticks(16'h0000, 8'h00, 8'h00, 1'b0, 8'h30, 8'hD0);
		send_packet(2'b00, 1'b0, 8'h08, 1'b0, 8'h06);
		send_packet(2'b01, 1'b0, 8'h40, 1'b1, 8'hF0);
		compare("port1_fire_n", 0, port1_fire_n);
		send_packet(2'b10, 1'b1, 8'hE8, 1'b0, 8'h03);
		send_packet(2'b00, 1'b0, 8'h01, 1'b1, 8'hFF);
		send_packet(2'b00, 1'b0, 8'h13, 1'b0, 8'h14);
	endtask

	task automatic test_saturation();
		repeat (16) send_packet(2'b00, 1'b0, 8'hFF, 1'b0, 8'hFF);
		compare("port1_x", 12'h000, port1_x);
		compare("port1_y", 12'hFFF, port1_y);
		repeat (27) send_packet(2'b00, 1'b1, 8'h00, 1'b1, 8'h00);
		compare("port1_x", 12'hFFF, port1_x);
		compare("port1_y", 12'h000, port1_y);
	endtask

	task automatic test_port_swap();
		set_swap(1'b1);
		send_packet(2'b01, 1'b0, 8'h20, 1'b1, 8'hE0);
		set_joysticks(16'h0010, 8'h55, 8'hAA, 1'b0, 8'h12, 8'hF3);
		set_joysticks(take_bits(16) | 16'h0010, take_bits(8), take_bits(8),
		              1'b1, take_bits(8), take_bits(8));
		set_swap(1'b0);
	endtask

	task automatic test_return_to_joystick();
		set_joysticks(16'h0000, 8'h11, 8'h22, 1'b0, 8'h00, 8'h00);
		send_packet(2'b01, 1'b0, 8'h10, 1'b0, 8'h0C);
		set_joysticks(16'h0001, 8'h11, 8'h22, 1'b0, 8'h00, 8'h00);
		set_joysticks(16'h0000, 8'h11, 8'h22, 1'b0, 8'h00, 8'h00);
		// restart from centre
		send_packet(2'b00, 1'b0, 8'h08, 1'b1, 8'hF8);
		set_disable(1'b1);
		send_packet(2'b11, 1'b0, 8'h40, 1'b0, 8'h40);
		set_disable(1'b0);
		send_packet(2'b00, 1'b1, 8'hF4, 1'b0, 8'h0A);
	endtask

	initial begin
		reset = 1'b1;
		mouse_pkt = '0;
		mouse_disable = 1'b0;
		port_swap = 1'b0;
		joy1 = '0;
		joy1_x = '0;
		joy1_y = '0;
		joy2_fire = 1'b0;
		joy2_x = '0;
		joy2_y = '0;
		stb = 1'b0;
		clear_model();
		repeat (RESET_CYCLES) @(posedge clk_sys);
		test_reset_state();
		test_joystick_passthrough();
		test_mouse_emulation();
		test_saturation();
		test_port_swap();
		test_return_to_joystick();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// ==== verilog/analog_input_top.sv ====
/*
  analog joystick front end top level
  mouse packet decoder, one accumulator per axis, port mapper
*/

`timescale 1ns/1ps

module analog_input_top #(
	parameter int delta_limit = analog_pkg::DEFAULT_DELTA_LIMIT
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  analog_pkg::mouse_pkt_t mouse_pkt,
	input  logic                   mouse_disable,
	input  logic                   port_swap,
	input  logic [15:0]            joy1,
	input  analog_pkg::joy_axis_t  joy1_x,
	input  analog_pkg::joy_axis_t  joy1_y,
	input  logic                   joy2_fire,
	input  analog_pkg::joy_axis_t  joy2_x,
	input  analog_pkg::joy_axis_t  joy2_y,
	output analog_pkg::port_axis_t port1_x,
	output analog_pkg::port_axis_t port1_y,
	output analog_pkg::port_axis_t port2_x,
	output analog_pkg::port_axis_t port2_y,
	output logic                   port1_fire_n,
	output logic                   port2_fire_n
);

	// decoder to accumulators
	logic                  delta_valid;
	analog_pkg::delta_t    delta [analog_pkg::NUM_AXES];
	logic                  axis_clear;
	// decoder to mapper
	analog_pkg::src_mode_e src_mode;
	logic                  mouse_fire;
	// accumulators to mapper
	analog_pkg::axis_t     axis_pos [analog_pkg::NUM_AXES];

	// ==============================
	// packet decoder
	// ==============================

	mouse_packet_decoder #(
		.delta_limit(delta_limit)
	) u_decoder (
		.clk_sys(clk_sys),
		.reset(reset),
		.mouse_pkt(mouse_pkt),
		.mouse_disable(mouse_disable),
		.joy1(joy1),
		.delta_valid(delta_valid),
		.delta(delta),
		.axis_clear(axis_clear),
		.src_mode(src_mode),
		.mouse_fire(mouse_fire)
	);

	// ==============================
	// axis accumulators
	// ==============================

	// index 0 is x, index 1 is y
	for (genvar i = 0; i < analog_pkg::NUM_AXES; i++) begin : g_axis
		mouse_axis_accum u_axis (
			.clk_sys(clk_sys),
			.reset(reset),
			.delta_valid(delta_valid),
			.delta(delta[i]),
			.axis_clear(axis_clear),
			.axis_pos(axis_pos[i])
		);
	end

	// ==============================
	// port mapper
	// ==============================

	joystick_port_mapper u_mapper (
		.clk_sys(clk_sys),
		.reset(reset),
		.src_mode(src_mode),
		.axis_pos(axis_pos),
		.mouse_fire(mouse_fire),
		.joy1_fire(joy1[analog_pkg::JOY_FIRE_BIT]),
		.joy1_x(joy1_x),
		.joy1_y(joy1_y),
		.joy2_fire(joy2_fire),
		.joy2_x(joy2_x),
		.joy2_y(joy2_y),
		.port_swap(port_swap),
		.port1_x(port1_x),
		.port1_y(port1_y),
		.port2_x(port2_x),
		.port2_y(port2_y),
		.port1_fire_n(port1_fire_n),
		.port2_fire_n(port2_fire_n)
	);

endmodule

// ==== verilog/analog_pkg.sv ====
/*
  shared types and constants for the analog joystick front end
  mouse packet layout, delta and axis types, port value type
  source-mode enum and default delta clamp limit
*/

package analog_pkg;

	// ==============================
	// mouse packet
	// ==============================

	// raw ps/2 mouse word, toggle strobe on top
	typedef logic [24:0] mouse_pkt_t;

	// bit positions inside the packet
	localparam int MOUSE_STB_BIT   = 24;
	localparam int MOUSE_LEFT_BIT  = 0;
	localparam int MOUSE_RIGHT_BIT = 1;
	localparam int MOUSE_X_SIGN    = 4;
	localparam int MOUSE_Y_SIGN    = 5;
	// lsb of each movement byte
	localparam int MOUSE_X_LSB     = 8;
	localparam int MOUSE_Y_LSB     = 16;

	// ==============================
	// axis types
	// ==============================

	// halved movement, sign repeated above bits 7:1
	typedef logic signed [8:0] delta_t;

	// accumulated position, kept inside AXIS_MIN..AXIS_MAX
	typedef logic signed [8:0] axis_t;
	localparam axis_t AXIS_MIN = -9'sd128;
	localparam axis_t AXIS_MAX = 9'sd127;

	// joystick analog byte, signed form
	typedef logic [7:0] joy_axis_t;

	// bbc port value: converted byte then its upper nibble
	typedef logic [11:0] port_axis_t;

	// x is index 0, y is index 1
	localparam int NUM_AXES = 2;
	localparam int AXIS_X   = 0;
	localparam int AXIS_Y   = 1;

	// fire button inside the 16-bit joystick word
	localparam int JOY_FIRE_BIT = 4;

	// ==============================
	// source selection
	// ==============================

	// which source feeds the first joystick
	typedef enum logic {
		SRC_JOYSTICK = 1'b0,
		SRC_MOUSE    = 1'b1
	} src_mode_e;

	// default clamp of one packet's delta
	localparam int DEFAULT_DELTA_LIMIT = 10;

endpackage

// ==== verilog/joystick_port_mapper.sv ====
/*
  joystick port mapper
  picks mouse or first joystick as source A, second joystick as B,
  converts to the bbc 12-bit port form, maps fire, swaps ports
*/

`timescale 1ns/1ps

module joystick_port_mapper (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  analog_pkg::src_mode_e src_mode,
	input  analog_pkg::axis_t     axis_pos [analog_pkg::NUM_AXES],
	input  logic                  mouse_fire,
	input  logic                  joy1_fire,
	input  analog_pkg::joy_axis_t joy1_x,
	input  analog_pkg::joy_axis_t joy1_y,
	input  logic                  joy2_fire,
	input  analog_pkg::joy_axis_t joy2_x,
	input  analog_pkg::joy_axis_t joy2_y,
	input  logic                  port_swap,
	output analog_pkg::port_axis_t port1_x,
	output analog_pkg::port_axis_t port1_y,
	output analog_pkg::port_axis_t port2_x,
	output analog_pkg::port_axis_t port2_y,
	output logic                  port1_fire_n,
	output logic                  port2_fire_n
);

	// source A selected values
	analog_pkg::joy_axis_t a_x;
	analog_pkg::joy_axis_t a_y;
	logic                  a_fire;

	// converted port values
	analog_pkg::port_axis_t pa_x;
	analog_pkg::port_axis_t pa_y;
	analog_pkg::port_axis_t pb_x;
	analog_pkg::port_axis_t pb_y;

	// signed byte to inverted offset binary, 12 bits
	// centre 00 gives 7f7, +127 gives 000, -128 gives fff
	function automatic analog_pkg::port_axis_t to_port(input analog_pkg::joy_axis_t v);
		analog_pkg::joy_axis_t c;
		c = 8'hFF - {~v[7], v[6:0]};
		// low nibble repeats the top for full-scale 12 bits
		return {c, c[7:4]};
	endfunction

	// ==============================
	// source selection
	// ==============================

	// mouse positions only use their low byte
	always_comb begin
		if (src_mode == analog_pkg::SRC_MOUSE) begin
			a_x    = axis_pos[analog_pkg::AXIS_X][7:0];
			a_y    = axis_pos[analog_pkg::AXIS_Y][7:0];
			a_fire = mouse_fire;
		end else begin
			a_x    = joy1_x;
			a_y    = joy1_y;
			a_fire = joy1_fire;
		end
	end

	// ==============================
	// conversion
	// ==============================

	assign pa_x = to_port(a_x);
	assign pa_y = to_port(a_y);
	// source B is always the second stick
	assign pb_x = to_port(joy2_x);
	assign pb_y = to_port(joy2_y);

	// ==============================
	// output registers
	// ==============================

	// axis values, swapped on request
	always_ff @(posedge clk_sys) begin
		if (port_swap) begin
			port1_x <= pb_x;
			port1_y <= pb_y;
			port2_x <= pa_x;
			port2_y <= pa_y;
		end else begin
			port1_x <= pa_x;
			port1_y <= pa_y;
			port2_x <= pb_x;
			port2_y <= pb_y;
		end
	end

	// fire is active low on the port
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			port1_fire_n <= 1'b1;
			port2_fire_n <= 1'b1;
		end else if (port_swap) begin
			port1_fire_n <= ~joy2_fire;
			port2_fire_n <= ~a_fire;
		end else begin
			port1_fire_n <= ~a_fire;
			port2_fire_n <= ~joy2_fire;
		end
	end

	// no stray fire right after reset
	a_fire_idle_after_reset: assert property (
		@(posedge clk_sys)
		reset |=> (port1_fire_n && port2_fire_n)
	);

endmodule

// ==== verilog/mouse_axis_accum.sv ====
/*
  saturating accumulator for one emulated analog axis
  adds each valid delta, clamps to the axis range, clears to zero
*/

`timescale 1ns/1ps

module mouse_axis_accum (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               delta_valid,
	input  analog_pkg::delta_t delta,
	input  logic               axis_clear,
	output analog_pkg::axis_t  axis_pos
);

	// one extra bit so the raw sum never wraps
	logic signed [9:0] sum;
	analog_pkg::axis_t next_pos;

	// ==============================
	// saturating add
	// ==============================

	// sign-extend both operands before adding
	assign sum = {axis_pos[8], axis_pos} + {delta[8], delta};

	always_comb begin
		if (sum > analog_pkg::AXIS_MAX)
			next_pos = analog_pkg::AXIS_MAX;
		else if (sum < analog_pkg::AXIS_MIN)
			next_pos = analog_pkg::AXIS_MIN;
		else
			next_pos = sum[8:0];
	end

	// ==============================
	// position register
	// ==============================

	// clear has priority, back to centre
	always_ff @(posedge clk_sys) begin
		if (reset || axis_clear)
			axis_pos <= '0;
		else if (delta_valid)
			axis_pos <= next_pos;
	end

	// low byte goes to the port, so range must hold
	a_pos_in_range: assert property (
		@(posedge clk_sys) disable iff (reset)
		(axis_pos >= analog_pkg::AXIS_MIN) && (axis_pos <= analog_pkg::AXIS_MAX)
	);

endmodule

// ==== verilog/mouse_packet_decoder.sv ====
/*
  mouse packet decoder
  strobe edge detection, halved and clamped axis deltas,
  mouse/joystick source state and mouse fire
*/

`timescale 1ns/1ps

module mouse_packet_decoder #(
	parameter int delta_limit = analog_pkg::DEFAULT_DELTA_LIMIT
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  analog_pkg::mouse_pkt_t mouse_pkt,
	input  logic                   mouse_disable,
	input  logic [15:0]            joy1,
	output logic                   delta_valid,
	output analog_pkg::delta_t     delta [analog_pkg::NUM_AXES],
	output logic                   axis_clear,
	output analog_pkg::src_mode_e  src_mode,
	output logic                   mouse_fire
);

	// clamp bounds in delta width
	localparam analog_pkg::delta_t LIMIT_POS = analog_pkg::delta_t'(delta_limit);
	localparam analog_pkg::delta_t LIMIT_NEG = -LIMIT_POS;

	logic               prev_stb;
	logic               new_pkt;
	logic               clear_req;
	analog_pkg::delta_t raw_dx;
	analog_pkg::delta_t raw_dy;
	analog_pkg::delta_t lim_dx;
	analog_pkg::delta_t lim_dy;

	// limit one delta to +-delta_limit
	function automatic analog_pkg::delta_t clamp_delta(input analog_pkg::delta_t d);
		if (d > LIMIT_POS)
			return LIMIT_POS;
		else if (d < LIMIT_NEG)
			return LIMIT_NEG;
		else
			return d;
	endfunction

	// ==============================
	// packet detection
	// ==============================

	// new packet on any change of the toggle strobe
	assign new_pkt = prev_stb != mouse_pkt[analog_pkg::MOUSE_STB_BIT];

	// real joystick activity or disable hands the port back
	assign clear_req = (|joy1) || mouse_disable;

	// 9-bit movement shifted right by one, sign kept
	assign raw_dx = {mouse_pkt[analog_pkg::MOUSE_X_SIGN],
	                 mouse_pkt[analog_pkg::MOUSE_X_SIGN],
	                 mouse_pkt[analog_pkg::MOUSE_X_LSB + 7 -: 7]};
	assign raw_dy = {mouse_pkt[analog_pkg::MOUSE_Y_SIGN],
	                 mouse_pkt[analog_pkg::MOUSE_Y_SIGN],
	                 mouse_pkt[analog_pkg::MOUSE_Y_LSB + 7 -: 7]};

	assign lim_dx = clamp_delta(raw_dx);
	assign lim_dy = clamp_delta(raw_dy);

	// delta payload, qualified by delta_valid
	// y flipped: mouse up means stick up, bbc y grows downward
	always_ff @(posedge clk_sys) begin
		if (new_pkt) begin
			delta[analog_pkg::AXIS_X] <= lim_dx;
			delta[analog_pkg::AXIS_Y] <= -lim_dy;
		end
	end

	// ==============================
	// source state
	// ==============================

	always_ff @(posedge clk_sys) begin
		// strobe sampled during reset too, so no packet at reset
		prev_stb <= mouse_pkt[analog_pkg::MOUSE_STB_BIT];
		if (reset) begin
			delta_valid <= 1'b0;
			axis_clear  <= 1'b0;
			src_mode    <= analog_pkg::SRC_JOYSTICK;
			mouse_fire  <= 1'b0;
		end else if (clear_req) begin
			// clear wins over a packet in the same cycle
			delta_valid <= 1'b0;
			axis_clear  <= 1'b1;
			src_mode    <= analog_pkg::SRC_JOYSTICK;
			mouse_fire  <= 1'b0;
		end else begin
			delta_valid <= new_pkt;
			axis_clear  <= 1'b0;
			if (new_pkt) begin
				src_mode   <= analog_pkg::SRC_MOUSE;
				// either button counts as fire
				mouse_fire <= mouse_pkt[analog_pkg::MOUSE_LEFT_BIT] |
				              mouse_pkt[analog_pkg::MOUSE_RIGHT_BIT];
			end
		end
	end

	// accumulators rely on never seeing both strobes at once
	a_no_valid_with_clear: assert property (
		@(posedge clk_sys) disable iff (reset)
		!(delta_valid && axis_clear)
	);

endmodule
